/* all.f */
common/calcPkg.sv
stackCtrl/stackCtrl.sv
source/pointerRegs.sv
source/valueDatapath.sv
source/stackRam.sv
source/stackCalc.sv
tb/clockGen.sv
tb/stackCalc_sva.sv
tb/stackCalcTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module stackCalcTb -f all.f \
    -o stackCalcSim && ./obj_dir/stackCalcSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation PASSED" sim.log && exit 0 || exit 1

/* tb/stackCalcTb.sv */
`timescale 1ns/10ps
`default_nettype none

module stackCalcTb;

    localparam int DataWidth = 8;
    localparam int AddrWidth = 7;
    localparam int NumPushes = 6;
    localparam int NumRandomCmds = 30;
    // about 60 commands of 9 cycles or fewer, plus margin
    localparam int TimeoutCycles = 1000;

    typedef struct packed {
        logic [DataWidth-1:0] value;
        logic                 valueKnown;
        logic [AddrWidth-1:0] addr;
        logic                 empty;
    } expectT;

    logic                 clk;
    logic                 rstN;
    logic                 cmdValid;
    calcPkg::opT          cmd;
    logic [DataWidth-1:0] switches;
    logic                 credit;
    logic [DataWidth-1:0] dispValue;
    logic [AddrWidth-1:0] dispAddr;
    logic                 stackEmpty;

    // model of the stack memory and pointers
    logic [DataWidth-1:0] modelMem [0:(1 << AddrWidth)-1];
    logic                 modelKnown [0:(1 << AddrWidth)-1];
    logic [AddrWidth-1:0] modelSp;
    logic [AddrWidth-1:0] modelDar;
    logic [DataWidth-1:0] modelDvr;
    logic                 modelDvrKnown;

    expectT expected;
    logic   hasCredit;
    logic   checkPending;
    string  testName;
    int     seed;
    int     cycleCount;
    int     testErrors;
    int     testChecks;
    int     totalErrors;
    int     failedTests;
    int     testsRun;

    clockGen #(.HalfPeriod(10), .ResetCycles(4)) clockGen_i (
        .clk  (clk),
        .rstN (rstN)
    );

    stackCalc #(.DataWidth(DataWidth), .AddrWidth(AddrWidth)) dut_i (
        .clk        (clk),
        .rstN       (rstN),
        .cmdValid   (cmdValid),
        .cmd        (cmd),
        .switches   (switches),
        .credit     (credit),
        .dispValue  (dispValue),
        .dispAddr   (dispAddr),
        .stackEmpty (stackEmpty)
    );

    // display register reloads from the model entry under dar
    function automatic void readDisplay();
        modelDvr = modelMem[modelDar];
        modelDvrKnown = modelKnown[modelDar];
    endfunction

    // steps the model by one command, returns the outputs expected after it
    function automatic expectT predictOutputs(calcPkg::opT op, logic [DataWidth-1:0] value);
        expectT               result;
        logic [DataWidth-1:0] opA;
        logic [DataWidth-1:0] opB;
        case (op)
            calcPkg::opPush: begin
                modelMem[modelSp] = value;
                modelKnown[modelSp] = 1'b1;
                modelSp = modelSp - 1'b1;
                modelDar = modelSp + 1'b1;
                readDisplay();
            end
            calcPkg::opPop: begin
                modelSp = modelSp + 1'b1;
                modelDar = modelSp + 1'b1;
                readDisplay();
            end
            calcPkg::opAdd, calcPkg::opSub: begin
                // B is the top, A the entry below it
                modelSp = modelSp + 1'b1;
                opB = modelMem[modelSp];
                modelSp = modelSp + 1'b1;
                opA = modelMem[modelSp];
                if (op == calcPkg::opSub) begin
                    modelDvr = opA - opB;
                end else begin
                    modelDvr = opA + opB;
                end
                modelDvrKnown = 1'b1;
                modelMem[modelSp] = modelDvr;
                modelKnown[modelSp] = 1'b1;
                modelSp = modelSp - 1'b1;
            end
            calcPkg::opDarDec: begin
                modelDar = modelDar - 1'b1;
                readDisplay();
            end
            calcPkg::opDarInc: begin
                modelDar = modelDar + 1'b1;
                readDisplay();
            end
            default: begin
                modelSp = '1;
                modelDar = '0;
                modelDvr = '0;
                modelDvrKnown = 1'b1;
            end
        endcase
        result.value = modelDvr;
        result.valueKnown = modelDvrKnown;
        result.addr = modelDar;
        result.empty = (modelSp == '1);
        return result;
    endfunction

    function automatic int modelDepth();
        return (1 << AddrWidth) - 1 - int'(modelSp);
    endfunction

    function automatic logic [DataWidth-1:0] randomValue();
        logic [31:0] randWord;
        randWord = $random(seed);
        return randWord[DataWidth-1:0];
    endfunction

    // random command, kept legal for the current depth
    function automatic calcPkg::opT pickCommand();
        logic [31:0] randWord;
        int          depth;
        calcPkg::opT op;
        randWord = $random(seed);
        depth = modelDepth();
        case (randWord % 6)
            0: op = calcPkg::opPush;
            1: op = calcPkg::opPop;
            2: op = calcPkg::opAdd;
            3: op = calcPkg::opSub;
            4: op = calcPkg::opDarDec;
            default: op = calcPkg::opDarInc;
        endcase
        if ((op == calcPkg::opPop && depth < 1) ||
            ((op == calcPkg::opAdd || op == calcPkg::opSub) && depth < 2)) begin
            op = calcPkg::opPush;
        end
        if (op == calcPkg::opPush && depth > 100) begin
            op = calcPkg::opPop;
        end
        return op;
    endfunction

    // hand one check to the compare process and wait for it
    task automatic requestCheck();
        @(posedge clk);
        #1;
        checkPending = 1'b1;
        wait (checkPending == 1'b0);
    endtask

    task automatic issueCommand(input calcPkg::opT op);
        logic [DataWidth-1:0] value;
        value = randomValue();
        @(posedge clk);
        #1;
        cmdValid = 1'b1;
        cmd = op;
        switches = value;
        hasCredit = 1'b0;
        expected = predictOutputs(op, value);
        @(posedge clk);
        #1;
        cmdValid = 1'b0;
        // credit pulse marks the last microword
        wait (hasCredit === 1'b1);
        requestCheck();
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrors = 0;
        testChecks = 0;
    endtask

    task automatic endTest();
        testsRun = testsRun + 1;
        totalErrors = totalErrors + testErrors;
        if (testErrors == 0) begin
            $display("test %s: ok, %0d checks", testName, testChecks);
        end else begin
            failedTests = failedTests + 1;
            $display("test %s: %0d errors in %0d checks", testName, testErrors, testChecks);
        end
    endtask

    // one credit back per command, never to a host that already holds it
    always @(negedge clk) begin
        if (credit === 1'b1) begin
            assert (!hasCredit) else begin
                $display("%s: credit returned while no command was in flight", testName);
                testErrors = testErrors + 1;
            end
            hasCredit = 1'b1;
        end
    end

    // compare mid-cycle, outputs settled since the cycle after the credit
    always @(negedge clk) begin
        if (checkPending) begin
            testChecks = testChecks + 1;
            assert (dispAddr === expected.addr) else begin
                $display("error: %s dispAddr expected %0d actual %0d",
                         testName, expected.addr, dispAddr);
                testErrors = testErrors + 1;
            end
            assert (stackEmpty === expected.empty) else begin
                $display("error: %s stackEmpty expected %0b actual %0b",
                         testName, expected.empty, stackEmpty);
                testErrors = testErrors + 1;
            end
            // entries never written have no defined value
            if (expected.valueKnown) begin
                assert (dispValue === expected.value) else begin
                    $display("error: %s dispValue expected %0h actual %0h",
                             testName, expected.value, dispValue);
                    testErrors = testErrors + 1;
                end
            end
            checkPending = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: the credit never returned, run stopped after %0d cycles",
                     TimeoutCycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        cmdValid = 1'b0;
        cmd = calcPkg::opReset;
        switches = '0;
        hasCredit = 1'b1;
        checkPending = 1'b0;
        seed = 32'hc8d4;
        cycleCount = 0;
        totalErrors = 0;
        failedTests = 0;
        testsRun = 0;
        for (int i = 0; i < (1 << AddrWidth); i++) begin
            modelKnown[i] = 1'b0;
        end
        wait (rstN === 1'b1);

        startTest("resetState");
        expected = predictOutputs(calcPkg::opReset, '0);
        requestCheck();
        endTest();

        startTest("push");
        repeat (NumPushes) issueCommand(calcPkg::opPush);
        endTest();

        startTest("pop");
        repeat (2) issueCommand(calcPkg::opPop);
        issueCommand(calcPkg::opPush);
        issueCommand(calcPkg::opPop);
        endTest();

        startTest("add");
        repeat (2) issueCommand(calcPkg::opPush);
        repeat (2) issueCommand(calcPkg::opAdd);
        endTest();

        startTest("sub");
        issueCommand(calcPkg::opPush);
        repeat (2) issueCommand(calcPkg::opSub);
        endTest();

        // up into older entries, then down past the top
        startTest("displayPointer");
        repeat (2) issueCommand(calcPkg::opDarInc);
        repeat (4) issueCommand(calcPkg::opDarDec);
        endTest();

        startTest("resetCommand");
        issueCommand(calcPkg::opReset);
        repeat (2) issueCommand(calcPkg::opPush);
        endTest();

        startTest("randomMix");
        repeat (NumRandomCmds) issueCommand(pickCommand());
        endTest();

        $display("tests run: %0d, failed: %0d, errors: %0d", testsRun, failedTests, totalErrors);
        if (totalErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/stackCalc_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module stackCalcSva #(
    parameter int MaxLatency = 12
) (
    input wire logic          clk,
    input wire logic          rstN,
    input wire logic          cmdValid,
    input wire logic          credit,
    input wire calcPkg::ctrlT ctrl
);

    logic hostCredit;
    int   waitCycles;

    // host side credit and cycles since the last command
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hostCredit <= 1'b1;
            waitCycles <= 0;
        end else if (cmdValid) begin
            hostCredit <= 1'b0;
            waitCycles <= 1;
        end else if (credit) begin
            hostCredit <= 1'b1;
            waitCycles <= 0;
        end else if (waitCycles != 0) begin
            waitCycles <= waitCycles + 1;
        end
    end

    cmdNeedsCredit: assert property (@(posedge clk) disable iff (!rstN)
        cmdValid |-> hostCredit)
        else $error("cmdValid raised while the host held no credit");

    weNeedsEn: assert property (@(posedge clk) ctrl.ramWe |-> ctrl.ramEn)
        else $error("ramWe high without ramEn");

    // sequencer back in stWait once reset has been seen
    creditLowAfterReset: assert property (@(posedge clk) !rstN |=> !credit)
        else $error("credit high in the cycle after reset");

    creditReturns: assert property (@(posedge clk) disable iff (!rstN)
        waitCycles <= MaxLatency)
        else $error("no credit within %0d cycles of a command", MaxLatency);

endmodule

bind stackCalc stackCalcSva stackCalcSva_i (
    .clk      (clk),
    .rstN     (rstN),
    .cmdValid (cmdValid),
    .credit   (credit),
    .ctrl     (ctrl)
);

`default_nettype wire

/* tb/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
    parameter int HalfPeriod  = 10,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic rstN
);

    // free-running clock, 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #(HalfPeriod);
            clk = ~clk;
        end
    end

    // reset released just after a rising edge, like the other inputs
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

/* source/stackCalc.sv */
`timescale 1ns/10ps
`default_nettype none

module stackCalc #(
    parameter int DataWidth = 8,
    parameter int AddrWidth = 7
) (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic                 cmdValid,
    input  wire calcPkg::opT          cmd,
    input  wire logic [DataWidth-1:0] switches,
    output logic                      credit,
    output logic [DataWidth-1:0]      dispValue,
    output logic [AddrWidth-1:0]      dispAddr,
    output logic                      stackEmpty
);

    calcPkg::ctrlT        ctrl;
    logic [AddrWidth-1:0] ramAddr;
    logic [DataWidth-1:0] ramWrData;
    logic [DataWidth-1:0] ramRdData;

    // microcode sequencer
    stackCtrl stackCtrl_i (
        .clk      (clk),
        .rstN     (rstN),
        .cmdValid (cmdValid),
        .cmd      (cmd),
        .ctrl     (ctrl),
        .credit   (credit)
    );

    // spr / dar and address select
    pointerRegs #(.AddrWidth(AddrWidth)) pointerRegs_i (
        .clk        (clk),
        .rstN       (rstN),
        .ctrl       (ctrl),
        .ramAddr    (ramAddr),
        .dispAddr   (dispAddr),
        .stackEmpty (stackEmpty)
    );

    valueDatapath #(.DataWidth(DataWidth)) valueDatapath_i (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .ramRdData (ramRdData),
        .switches  (switches),
        .ramWrData (ramWrData),
        .dispValue (dispValue)
    );

    stackRam #(.DataWidth(DataWidth), .AddrWidth(AddrWidth)) stackRam_i (
        .clk       (clk),
        .ramEn     (ctrl.ramEn),
        .ramWe     (ctrl.ramWe),
        .ramAddr   (ramAddr),
        .ramWrData (ramWrData),
        .ramRdData (ramRdData)
    );

endmodule

`default_nettype wire

/* source/stackRam.sv */
`timescale 1ns/10ps
`default_nettype none

module stackRam #(
    parameter int DataWidth = 8,
    parameter int AddrWidth = 7
) (
    input  wire logic                 clk,
    input  wire logic                 ramEn,
    input  wire logic                 ramWe,
    input  wire logic [AddrWidth-1:0] ramAddr,
    input  wire logic [DataWidth-1:0] ramWrData,
    output logic [DataWidth-1:0]      ramRdData
);

    logic [DataWidth-1:0] mem [0:(1 << AddrWidth)-1];

    // single port, read data registered and held between reads
    always_ff @(posedge clk) begin
        if (ramEn) begin
            if (ramWe) begin
                mem[ramAddr] <= ramWrData;
            end else begin
                ramRdData <= mem[ramAddr];
            end
        end
    end

endmodule

`default_nettype wire

/* source/valueDatapath.sv */
`timescale 1ns/10ps
`default_nettype none

module valueDatapath #(
    parameter int DataWidth = 8
) (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire calcPkg::ctrlT        ctrl,
    input  wire logic [DataWidth-1:0] ramRdData,
    input  wire logic [DataWidth-1:0] switches,
    output logic [DataWidth-1:0]      ramWrData,
    output logic [DataWidth-1:0]      dispValue
);

    logic [DataWidth-1:0] opAQ;
    logic [DataWidth-1:0] opBQ;
    logic [DataWidth-1:0] dvrQ;
    logic [DataWidth-1:0] aluOut;
    logic [DataWidth-1:0] dvrNext;

    // operands only ever come from the stack
    always_ff @(posedge clk) begin
        if (ctrl.opALoad) begin
            opAQ <= ramRdData;
        end
        if (ctrl.opBLoad) begin
            opBQ <= ramRdData;
        end
    end

    // A is the deeper entry, B the top, wraps at DataWidth
    assign aluOut = ctrl.aluSub ? (opAQ - opBQ) : (opAQ + opBQ);

    always_comb begin
        case (ctrl.dvrSel)
            calcPkg::dvrRam: dvrNext = ramRdData;
            calcPkg::dvrAlu: dvrNext = aluOut;
            default:         dvrNext = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dvrQ <= '0;
        end else if (ctrl.dvrLoad) begin
            dvrQ <= dvrNext;
        end
    end

    // push stores switches, add/sub store the result
    assign ramWrData = ctrl.wrFromAlu ? aluOut : switches;
    assign dispValue = dvrQ;

endmodule

`default_nettype wire

/* source/pointerRegs.sv */
`timescale 1ns/10ps
`default_nettype none

module pointerRegs #(
    parameter int AddrWidth = 7
) (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire calcPkg::ctrlT        ctrl,
    output logic [AddrWidth-1:0]      ramAddr,
    output logic [AddrWidth-1:0]      dispAddr,
    output logic                      stackEmpty
);

    logic [AddrWidth-1:0] sprQ;
    logic [AddrWidth-1:0] darQ;
    logic [AddrWidth-1:0] sprPlus1;
    logic [AddrWidth-1:0] sprNext;
    logic [AddrWidth-1:0] darNext;

    // spr points at the next free slot, stack grows downward
    assign sprPlus1 = sprQ + 1'b1;

    always_comb begin
        case (ctrl.sprSel)
            calcPkg::sprInit: sprNext = '1;
            calcPkg::sprDec:  sprNext = sprQ - 1'b1;
            calcPkg::sprInc:  sprNext = sprPlus1;
            default:          sprNext = sprQ;
        endcase
    end

    always_comb begin
        case (ctrl.darSel)
            calcPkg::darInit:    darNext = '0;
            calcPkg::darFromSpr: darNext = sprPlus1;
            calcPkg::darDec:     darNext = darQ - 1'b1;
            default:             darNext = darQ + 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            sprQ <= '1;
            darQ <= '0;
        end else begin
            if (ctrl.sprLoad) begin
                sprQ <= sprNext;
            end
            if (ctrl.darLoad) begin
                darQ <= darNext;
            end
        end
    end

    assign ramAddr    = ctrl.addrFromDar ? darQ : sprQ;
    assign dispAddr   = darQ;
    // nothing pushed while spr still at top of memory
    assign stackEmpty = &sprQ;

endmodule

`default_nettype wire

/* stackCtrl/stackCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module stackCtrl (
    input  wire logic          clk,
    input  wire logic          rstN,
    input  wire logic          cmdValid,
    input  wire calcPkg::opT   cmd,
    output calcPkg::ctrlT      ctrl,
    output logic               credit
);

    calcPkg::stateT stateQ;
    calcPkg::stateT stateNext;
    calcPkg::stateT microNext;
    calcPkg::stateT entryState;

    // microword table, purely from current state
    always_comb begin
        ctrl = '0;
        case (stateQ)
            calcPkg::stReset: begin
                // all three registers back to init values
                ctrl.sprSel  = calcPkg::sprInit;
                ctrl.sprLoad = 1'b1;
                ctrl.darSel  = calcPkg::darInit;
                ctrl.darLoad = 1'b1;
                ctrl.dvrSel  = calcPkg::dvrInit;
                ctrl.dvrLoad = 1'b1;
            end
            calcPkg::stPush: begin
                // switches into the free slot at spr
                ctrl.ramEn = 1'b1;
                ctrl.ramWe = 1'b1;
            end
            calcPkg::stSprDec: begin
                ctrl.sprSel  = calcPkg::sprDec;
                ctrl.sprLoad = 1'b1;
            end
            calcPkg::stPop, calcPkg::stAddSprIncB, calcPkg::stAddSprIncA,
            calcPkg::stSubSprIncB, calcPkg::stSubSprIncA: begin
                ctrl.sprSel  = calcPkg::sprInc;
                ctrl.sprLoad = 1'b1;
            end
            calcPkg::stDarFromSpr: begin
                // display follows new top of stack
                ctrl.darSel  = calcPkg::darFromSpr;
                ctrl.darLoad = 1'b1;
            end
            calcPkg::stDarDec: begin
                ctrl.darSel  = calcPkg::darDec;
                ctrl.darLoad = 1'b1;
            end
            calcPkg::stDarInc: begin
                ctrl.darSel  = calcPkg::darInc;
                ctrl.darLoad = 1'b1;
            end
            calcPkg::stReqDvr: begin
                ctrl.addrFromDar = 1'b1;
                ctrl.ramEn       = 1'b1;
            end
            calcPkg::stLoadDvr: begin
                // read data arrives one cycle after the request
                ctrl.dvrSel  = calcPkg::dvrRam;
                ctrl.dvrLoad = 1'b1;
            end
            calcPkg::stAddReqB, calcPkg::stAddReqA,
            calcPkg::stSubReqB, calcPkg::stSubReqA: begin
                ctrl.ramEn = 1'b1;
            end
            calcPkg::stAddLoadB, calcPkg::stSubLoadB: begin
                ctrl.opBLoad = 1'b1;
            end
            calcPkg::stAddLoadA, calcPkg::stSubLoadA: begin
                ctrl.opALoad = 1'b1;
            end
            calcPkg::stAddStore, calcPkg::stSubStore: begin
                // result over A's slot, spr steps back so A's slot is the new top
                ctrl.aluSub    = (stateQ == calcPkg::stSubStore);
                ctrl.wrFromAlu = 1'b1;
                ctrl.ramEn     = 1'b1;
                ctrl.ramWe     = 1'b1;
                ctrl.dvrSel    = calcPkg::dvrAlu;
                ctrl.dvrLoad   = 1'b1;
                ctrl.sprSel    = calcPkg::sprDec;
                ctrl.sprLoad   = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // successor of each microword
    always_comb begin
        case (stateQ)
            calcPkg::stPush:       microNext = calcPkg::stSprDec;
            calcPkg::stSprDec:     microNext = calcPkg::stDarFromSpr;
            calcPkg::stPop:        microNext = calcPkg::stDarFromSpr;
            calcPkg::stDarFromSpr: microNext = calcPkg::stReqDvr;
            calcPkg::stDarDec:     microNext = calcPkg::stReqDvr;
            calcPkg::stDarInc:     microNext = calcPkg::stReqDvr;
            calcPkg::stReqDvr:     microNext = calcPkg::stLoadDvr;
            calcPkg::stAddSprIncB: microNext = calcPkg::stAddReqB;
            calcPkg::stAddReqB:    microNext = calcPkg::stAddLoadB;
            calcPkg::stAddLoadB:   microNext = calcPkg::stAddSprIncA;
            calcPkg::stAddSprIncA: microNext = calcPkg::stAddReqA;
            calcPkg::stAddReqA:    microNext = calcPkg::stAddLoadA;
            calcPkg::stAddLoadA:   microNext = calcPkg::stAddStore;
            calcPkg::stSubSprIncB: microNext = calcPkg::stSubReqB;
            calcPkg::stSubReqB:    microNext = calcPkg::stSubLoadB;
            calcPkg::stSubLoadB:   microNext = calcPkg::stSubSprIncA;
            calcPkg::stSubSprIncA: microNext = calcPkg::stSubReqA;
            calcPkg::stSubReqA:    microNext = calcPkg::stSubLoadA;
            calcPkg::stSubLoadA:   microNext = calcPkg::stSubStore;
            default:               microNext = calcPkg::stWait;
        endcase
    end

    // first microword of each command
    always_comb begin
        case (cmd)
            calcPkg::opReset:  entryState = calcPkg::stReset;
            calcPkg::opPush:   entryState = calcPkg::stPush;
            calcPkg::opPop:    entryState = calcPkg::stPop;
            calcPkg::opAdd:    entryState = calcPkg::stAddSprIncB;
            calcPkg::opSub:    entryState = calcPkg::stSubSprIncB;
            calcPkg::opDarDec: entryState = calcPkg::stDarDec;
            calcPkg::opDarInc: entryState = calcPkg::stDarInc;
            default:           entryState = calcPkg::stWait;
        endcase
    end

    // commands only taken while idle
    assign stateNext = (stateQ == calcPkg::stWait) ?
                       (cmdValid ? entryState : calcPkg::stWait) : microNext;

    // last microword of a sequence hands the credit back
    assign credit = (stateQ != calcPkg::stWait) && (microNext == calcPkg::stWait);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stateQ <= calcPkg::stWait;
        end else begin
            stateQ <= stateNext;
        end
    end

endmodule

`default_nettype wire

/* common/calcPkg.sv */
`default_nettype none

package calcPkg;

    // host command codes
    typedef enum logic [2:0] {
        opReset  = 3'd0,
        opPush   = 3'd1,
        opPop    = 3'd2,
        opAdd    = 3'd3,
        opSub    = 3'd4,
        opDarDec = 3'd5,
        opDarInc = 3'd6
    } opT;

    // sequencer states, one per microword
    typedef enum logic [4:0] {
        stWait       = 5'd0,
        stReset      = 5'd1,
        stPush       = 5'd2,
        stSprDec     = 5'd3,
        stDarFromSpr = 5'd4,
        stReqDvr     = 5'd5,
        stLoadDvr    = 5'd6,
        stPop        = 5'd7,
        stSubSprIncB = 5'd8,
        stSubReqB    = 5'd9,
        stSubLoadB   = 5'd10,
        stSubSprIncA = 5'd11,
        stSubReqA    = 5'd12,
        stSubLoadA   = 5'd13,
        stSubStore   = 5'd14,
        stAddSprIncB = 5'd15,
        stAddReqB    = 5'd16,
        stAddLoadB   = 5'd17,
        stAddSprIncA = 5'd18,
        stAddReqA    = 5'd19,
        stAddLoadA   = 5'd20,
        stAddStore   = 5'd21,
        stDarDec     = 5'd22,
        stDarInc     = 5'd23
    } stateT;

    // stack pointer source, init is all ones (empty stack)
    typedef enum logic [1:0] {
        sprInit = 2'd0,
        sprDec  = 2'd1,
        sprInc  = 2'd2
    } sprSelT;

    // display pointer source
    typedef enum logic [1:0] {
        darInit    = 2'd0,
        darFromSpr = 2'd1,
        darDec     = 2'd2,
        darInc     = 2'd3
    } darSelT;

    // display value source
    typedef enum logic [1:0] {
        dvrInit = 2'd0,
        dvrRam  = 2'd1,
        dvrAlu  = 2'd2
    } dvrSelT;

    // one microword, fanned out to the datapath blocks
    typedef struct packed {
        sprSelT sprSel;
        logic   sprLoad;
        darSelT darSel;
        logic   darLoad;
        dvrSelT dvrSel;
        logic   dvrLoad;
        logic   addrFromDar;
        logic   opALoad;
        logic   opBLoad;
        logic   aluSub;
        logic   wrFromAlu;
        logic   ramEn;
        logic   ramWe;
    } ctrlT;

endpackage

`default_nettype wire
